/* testbench/fp_add_cases.txt */
# a b op rnd_mode result flags, all hex; op 0 add 1 sub; rnd 0 ne 1 rz 2 rp 3 rm
# flags: bit2 overflow, bit1 underflow, bit0 inexact
3f800000 3f800000 0 0 40000000 0
3fc00000 3f000000 1 0 3f800000 0
40000000 c0400000 0 1 bf800000 0
bf800000 c0200000 1 2 3fc00000 0
3f800000 33800000 1 0 3f7fffff 0
3f800000 33800000 0 0 3f800000 1
3f800000 33800000 0 1 3f800000 1
3f800000 33800000 0 2 3f800001 1
3f800000 33800000 0 3 3f800000 1
bf800000 b3800000 0 3 bf800001 1
3f800001 33800000 0 0 3f800002 1
3f800000 33c00000 0 0 3f800001 1
3fffffff 33800000 0 0 40000000 1
3f800000 3f7fffff 1 0 33800000 0
3fc00000 3fc00000 1 0 00000000 0
3fc00000 3fc00000 1 2 00000000 0
3fc00000 3fc00000 1 3 80000000 0
3f800000 bf800000 0 3 80000000 0
7f7fffff 7f7fffff 0 0 7f800000 5
7f7fffff 7f7fffff 0 1 7f7fffff 5
7f7fffff 7f7fffff 0 3 7f7fffff 5
ff7fffff ff7fffff 0 3 ff800000 5
ff7fffff ff7fffff 0 2 ff7fffff 5
7f7fffff 73000000 0 0 7f800000 5

/* compile.f */
verilog/fp_format_pkg.sv
verilog/fp_ctrl_pkg.sv
verilog/fp_align.sv
verilog/fp_sig_add.sv
verilog/fp_norm_round.sv
verilog/fp_result_pack.sv
verilog/fp_add_top.sv
testbench/fp_add_asserts.sv
testbench/tb_fp_add_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fp adder testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_fp_add_top -o sim_fp_add > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
# a simulator that dies early counts as a failed run
./obj_dir/sim_fp_add > sim.log 2>&1 || echo "Simulation failed" >> sim.log
! grep -q "Simulation failed" sim.log && echo "run passed, see sim.log" \
  || { echo "run failed, see sim.log"; exit 1; }

/* testbench/tb_fp_add_top.sv */
`timescale 1ns/1ns
module tb_fp_add_top;

  logic                                clk;
  logic                                rst;
  logic                                in_valid;
  logic [fp_format_pkg::WORD_W-1:0]    a;
  logic [fp_format_pkg::WORD_W-1:0]    b;
  fp_ctrl_pkg::fp_op_e                 op;
  fp_ctrl_pkg::fp_rnd_e                rnd_mode;
  logic                                out_valid;
  logic [fp_format_pkg::WORD_W-1:0]    result;
  logic                                overflow;
  logic                                underflow;
  logic                                inexact;

  // one expected entry per strobe in issue order
  logic [31:0] want_result_q[$];
  logic [3:0]  want_flags_q[$];  // bit2 overflow, bit1 underflow, bit0 inexact
  int          issue_cycle_q[$];
  int          case_id_q[$];

  int cycle;    // posedges seen so far
  int n_cases;
  int n_pass;
  int n_fail;
  int n_err;    // timeouts, stray strobes, file trouble

  fp_add_top dut (
    .clk(clk), .rst(rst), .in_valid(in_valid), .a(a), .b(b), .op(op),
    .rnd_mode(rnd_mode), .out_valid(out_valid), .result(result),
    .overflow(overflow), .underflow(underflow), .inexact(inexact)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  always @(posedge clk) cycle <= cycle + 1;

  // prints a FAIL line and returns 1 when got differs from want
  function automatic bit value_mismatch(int id, string name, logic [31:0] want,
                                        logic [31:0] got);
    if (got !== want) begin
      $display("FAIL case %0d: %s expected %h got %h", id, name, want, got);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  // compares one finished operation with the queue head
  task automatic check_output();
    logic [31:0] want_res;
    logic [3:0]  want_flags;
    int          id;
    int          latency;
    bit          bad;
    if (want_result_q.size() == 0) begin
      $display("out_valid was high at cycle %0d with no operation in flight", cycle);
      n_err++;
    end else begin
      want_res   = want_result_q.pop_front();
      want_flags = want_flags_q.pop_front();
      id         = case_id_q.pop_front();
      latency    = cycle - issue_cycle_q.pop_front();
      bad = 1'b0;
      bad |= value_mismatch(id, "result", want_res, result);
      bad |= value_mismatch(id, "overflow", 32'(want_flags[2]), 32'(overflow));
      bad |= value_mismatch(id, "underflow", 32'(want_flags[1]), 32'(underflow));
      bad |= value_mismatch(id, "inexact", 32'(want_flags[0]), 32'(inexact));
      if (latency != 3) begin
        $display("case %0d came out %0d cycles after its strobe, not 3", id, latency);
        bad = 1'b1;
      end
      if (bad) begin
        n_fail++;
        $display("case %0d failed", id);
      end else begin
        n_pass++;
        $display("case %0d ok: %h", id, result);
      end
    end
  endtask

  // outputs are stable by the falling edge
  always @(negedge clk) begin
    if (!rst && out_valid) check_output();
  end

  initial begin
    int          fd;
    string       line;
    logic [31:0] f_a, f_b, f_res;
    logic [3:0]  f_op, f_rnd, f_flags;
    int          wait_cnt;
    rst      = 1'b1;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    op       = fp_ctrl_pkg::OP_ADD;
    rnd_mode = fp_ctrl_pkg::RND_NE;
    repeat (4) @(negedge clk); // reset over 4 posedges
    rst = 1'b0;

    fd = $fopen("testbench/fp_add_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/fp_add_cases.txt");
      n_err++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        // comment and blank lines give fewer than 6 fields
        if ($fgets(line, fd) > 0 &&
            $sscanf(line, "%h %h %h %h %h %h", f_a, f_b, f_op, f_rnd, f_res, f_flags) == 6) begin
          @(negedge clk); // one case per cycle
          in_valid = 1'b1;
          a        = f_a;
          b        = f_b;
          op       = fp_ctrl_pkg::fp_op_e'(f_op[0]);
          rnd_mode = fp_ctrl_pkg::fp_rnd_e'(f_rnd[1:0]);
          want_result_q.push_back(f_res);
          want_flags_q.push_back(f_flags);
          issue_cycle_q.push_back(cycle);
          case_id_q.push_back(n_cases);
          n_cases++;
        end
      end
      $fclose(fd);
    end
    @(negedge clk);
    in_valid = 1'b0;

    // drain the pipe
    wait_cnt = 0;
    while (want_result_q.size() != 0 && wait_cnt < 20) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (want_result_q.size() != 0) begin
      $display("timed out with %0d results still missing", want_result_q.size());
      n_err++;
    end

    $display("cases %0d, passed %0d, failed %0d, other errors %0d",
             n_cases, n_pass, n_fail, n_err);
    if (n_cases > 0 && n_pass == n_cases && n_fail == 0 && n_err == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* testbench/fp_add_asserts.sv */
`timescale 1ns/1ns
module fp_add_asserts (
  input logic                                clk,
  input logic                                rst,
  input logic                                in_valid,
  input fp_ctrl_pkg::fp_rnd_e                rnd_mode,
  input logic                                out_valid,
  input logic                                overflow,
  input logic                                inexact,
  input logic [fp_format_pkg::WORD_W-1:0]    result
);

  // pipe is empty right after reset
  assert property (@(posedge clk) $past(rst) |-> !out_valid)
    else $error("out_valid high in the cycle after reset");

  // fixed three stage latency
  assert property (@(posedge clk) disable iff (rst) $past(in_valid, 3) |-> out_valid)
    else $error("in_valid not followed by out_valid three cycles later");

  // overflow is inexact and saturates as the issued mode says
  assert property (@(posedge clk) disable iff (rst)
    overflow |-> inexact &&
      ((result[fp_format_pkg::WORD_W-2:0] ==
        {fp_format_pkg::EXP_MAX, {fp_format_pkg::MANT_W{1'b0}}}) ==
       ($past(rnd_mode, 3) == fp_ctrl_pkg::RND_NE ||
        ($past(rnd_mode, 3) == fp_ctrl_pkg::RND_RP && !result[fp_format_pkg::WORD_W-1]) ||
        ($past(rnd_mode, 3) == fp_ctrl_pkg::RND_RM && result[fp_format_pkg::WORD_W-1]))))
    else $error("overflow without inexact or saturated to the wrong value");

endmodule

bind fp_add_top fp_add_asserts u_asserts (
  .clk(clk), .rst(rst), .in_valid(in_valid), .rnd_mode(rnd_mode), .out_valid(out_valid),
  .overflow(overflow), .inexact(inexact), .result(result)
);

/* verilog/fp_add_top.sv */
`timescale 1ns/1ns
module fp_add_top (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 in_valid,
  input  logic [fp_format_pkg::WORD_W-1:0]     a,
  input  logic [fp_format_pkg::WORD_W-1:0]     b,
  input  fp_ctrl_pkg::fp_op_e                  op,
  input  fp_ctrl_pkg::fp_rnd_e                 rnd_mode,
  output logic                                 out_valid,
  output logic [fp_format_pkg::WORD_W-1:0]     result,
  output logic                                 overflow,
  output logic                                 underflow,
  output logic                                 inexact
);
  // stage 1 to stage 2
  logic                                s1_valid, s1_sign, s1_eff_sub;
  logic [fp_format_pkg::EXP_W-1:0]     s1_exp;
  logic [fp_format_pkg::ALIGN_W-1:0]   s1_sig_big, s1_sig_small;
  logic [1:0]                          s1_rnd;
  // stage 2 to normalize/round
  logic                                s2_valid, s2_sign;
  logic [fp_format_pkg::EXP_W-1:0]     s2_exp;
  logic [fp_format_pkg::WORK_W-1:0]    s2_mant;
  logic [1:0]                          s2_rnd;
  // normalize/round to output register
  logic                                nr_sign, nr_overflow, nr_underflow, nr_inexact, nr_zero;
  logic [fp_format_pkg::EXP_W-1:0]     nr_exp;
  logic [fp_format_pkg::MANT_W-1:0]    nr_mant;

  fp_align u_align (
    .clk(clk), .rst(rst), .in_valid(in_valid), .a(a), .b(b), .op(op),
    .rnd_mode(rnd_mode), .s1_valid(s1_valid), .s1_sign(s1_sign),
    .s1_eff_sub(s1_eff_sub), .s1_exp(s1_exp), .s1_sig_big(s1_sig_big),
    .s1_sig_small(s1_sig_small), .s1_rnd(s1_rnd)
  );

  fp_sig_add u_sig_add (
    .clk(clk), .rst(rst), .s1_valid(s1_valid), .s1_sign(s1_sign),
    .s1_eff_sub(s1_eff_sub), .s1_exp(s1_exp), .s1_sig_big(s1_sig_big),
    .s1_sig_small(s1_sig_small), .s1_rnd(s1_rnd), .s2_valid(s2_valid),
    .s2_sign(s2_sign), .s2_exp(s2_exp), .s2_mant(s2_mant), .s2_rnd(s2_rnd)
  );

  fp_norm_round u_norm_round (
    .sign_in(s2_sign), .exp_in(s2_exp), .mant_in(s2_mant),
    .rnd_mode(fp_ctrl_pkg::fp_rnd_e'(s2_rnd)), .sign_out(nr_sign), .exp_out(nr_exp),
    .mant_out(nr_mant), .overflow(nr_overflow), .underflow(nr_underflow),
    .inexact(nr_inexact), .zero(nr_zero)
  );

  fp_result_pack u_result_pack (
    .clk(clk), .rst(rst), .s2_valid(s2_valid), .rnd_mode(fp_ctrl_pkg::fp_rnd_e'(s2_rnd)),
    .sign(nr_sign), .exp(nr_exp), .mant(nr_mant), .overflow_in(nr_overflow),
    .underflow_in(nr_underflow), .inexact_in(nr_inexact), .zero(nr_zero),
    .out_valid(out_valid), .result(result), .overflow(overflow),
    .underflow(underflow), .inexact(inexact)
  );

endmodule

/* verilog/fp_result_pack.sv */
`timescale 1ns/1ns
module fp_result_pack (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 s2_valid,
  input  fp_ctrl_pkg::fp_rnd_e                 rnd_mode,
  input  logic                                 sign,
  input  logic [fp_format_pkg::EXP_W-1:0]      exp,
  input  logic [fp_format_pkg::MANT_W-1:0]     mant,
  input  logic                                 overflow_in,
  input  logic                                 underflow_in,
  input  logic                                 inexact_in,
  input  logic                                 zero,
  output logic                                 out_valid,
  output logic [fp_format_pkg::WORD_W-1:0]     result,
  output logic                                 overflow,
  output logic                                 underflow,
  output logic                                 inexact
);
  logic                              to_inf;  // overflow saturates to infinity
  logic                              ovf;
  logic [fp_format_pkg::WORD_W-1:0]  packed_word;

  assign to_inf = (rnd_mode == fp_ctrl_pkg::RND_NE) |
                  ((rnd_mode == fp_ctrl_pkg::RND_RP) & ~sign) |
                  ((rnd_mode == fp_ctrl_pkg::RND_RM) & sign);
  assign ovf = overflow_in & ~zero;

  always_comb begin
    if (zero) begin
      packed_word = {rnd_mode == fp_ctrl_pkg::RND_RM, {(fp_format_pkg::WORD_W-1){1'b0}}};
    end else if (ovf && to_inf) begin
      packed_word = {sign, fp_format_pkg::EXP_MAX, {fp_format_pkg::MANT_W{1'b0}}};
    end else if (ovf) begin
      // largest finite of the same sign
      packed_word = {sign, fp_format_pkg::MAX_FINITE_EXP, {fp_format_pkg::MANT_W{1'b1}}};
    end else begin
      packed_word = {sign, exp, mant};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      result    <= '0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
      inexact   <= 1'b0;
    end else begin
      out_valid <= s2_valid;
      overflow  <= s2_valid & ovf;             // flags only with a valid result
      underflow <= s2_valid & underflow_in & ~zero;
      inexact   <= s2_valid & (inexact_in | ovf);
      if (s2_valid) result <= packed_word;     // holds between results
    end
  end

endmodule

/* verilog/fp_norm_round.sv */
`timescale 1ns/1ns
module fp_norm_round (
  input  logic                                 sign_in,
  input  logic [fp_format_pkg::EXP_W-1:0]      exp_in,   // biased
  input  logic [fp_format_pkg::WORK_W-1:0]     mant_in,  // carry|sig|g|r|s
  input  fp_ctrl_pkg::fp_rnd_e                 rnd_mode,
  output logic                                 sign_out,
  output logic [fp_format_pkg::EXP_W-1:0]      exp_out,
  output logic [fp_format_pkg::MANT_W-1:0]     mant_out,
  output logic                                 overflow,
  output logic                                 underflow,
  output logic                                 inexact,
  output logic                                 zero
);
  logic [fp_format_pkg::WORK_W-1:0] working;
  logic [4:0]                       lzc;     // 0..27
  logic [4:0]                       shamt;
  logic [fp_format_pkg::SIG_W-1:0]  sig;
  logic                             g, r, s;
  logic                             round_inc;
  logic [fp_format_pkg::SIG_W:0]    rounded; // extra bit for rounding carry

  assign sign_out = sign_in;
  assign zero     = (mant_in == '0);

  // leading zeros below the carry bit, highest set bit wins
  always_comb begin
    lzc = 5'(fp_format_pkg::WORK_W - 1);
    for (int i = 0; i < fp_format_pkg::WORK_W - 1; i++) begin
      if (mant_in[i]) lzc = 5'(fp_format_pkg::WORK_W - 2 - i);
    end
  end

  always_comb begin
    shamt = lzc;
    if (mant_in[fp_format_pkg::WORK_W-1]) begin
      // adder carry, one place right, keep the dropped bit in s
      working = {1'b0, mant_in[fp_format_pkg::WORK_W-1:2], mant_in[1] | mant_in[0]};
      exp_out = exp_in + 1'b1;
    end else begin
      if ({3'b000, lzc} > exp_in) shamt = exp_in[4:0]; // exponent floors at zero
      working = mant_in << shamt;
      exp_out = exp_in - {3'b000, shamt};
    end

    sig = working[fp_format_pkg::WORK_W-2:3];
    g   = working[2];
    r   = working[1];
    s   = working[0];
    inexact = g | r | s;

    case (rnd_mode)
      fp_ctrl_pkg::RND_NE: round_inc = g & (r | s | sig[0]); // tie goes to even
      fp_ctrl_pkg::RND_RZ: round_inc = 1'b0;
      fp_ctrl_pkg::RND_RP: round_inc = ~sign_in & inexact;
      fp_ctrl_pkg::RND_RM: round_inc = sign_in & inexact;
      default:             round_inc = 1'b0;
    endcase

    rounded = {1'b0, sig} + {{fp_format_pkg::SIG_W{1'b0}}, round_inc};
    if (rounded[fp_format_pkg::SIG_W]) begin
      // 1.111..1 rounded up to 10.000..0
      mant_out = rounded[fp_format_pkg::MANT_W:1];
      exp_out  = exp_out + 1'b1;
    end else begin
      mant_out = rounded[fp_format_pkg::MANT_W-1:0]; // hidden bit dropped
    end

    overflow  = (exp_out == fp_format_pkg::EXP_MAX);
    underflow = (exp_out == '0) & inexact; // rough subnormal rule
  end

endmodule

/* verilog/fp_sig_add.sv */
`timescale 1ns/1ns
module fp_sig_add (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 s1_valid,
  input  logic                                 s1_sign,
  input  logic                                 s1_eff_sub,
  input  logic [fp_format_pkg::EXP_W-1:0]      s1_exp,
  input  logic [fp_format_pkg::ALIGN_W-1:0]    s1_sig_big,
  input  logic [fp_format_pkg::ALIGN_W-1:0]    s1_sig_small,
  input  logic [1:0]                           s1_rnd,
  output logic                                 s2_valid,
  output logic                                 s2_sign,
  output logic [fp_format_pkg::EXP_W-1:0]      s2_exp,
  output logic [fp_format_pkg::WORK_W-1:0]     s2_mant,
  output logic [1:0]                           s2_rnd
);
  logic [fp_format_pkg::WORK_W-1:0] big_ext;   // zero carry bit on top
  logic [fp_format_pkg::WORK_W-1:0] small_ext;
  logic [fp_format_pkg::WORK_W-1:0] sum;

  assign big_ext   = {1'b0, s1_sig_big};
  assign small_ext = {1'b0, s1_sig_small};

  // big >= small so the difference stays positive
  // carry of an add lands in bit WORK_W-1
  assign sum = s1_eff_sub ? (big_ext - small_ext) : (big_ext + small_ext);

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
      s2_sign  <= 1'b0;
      s2_exp   <= '0;
      s2_mant  <= '0;
      s2_rnd   <= '0;
    end else begin
      s2_valid <= s1_valid;
      s2_sign  <= s1_sign;   // unchanged, magnitude order fixed in stage 1
      s2_exp   <= s1_exp;
      s2_mant  <= sum;       // carry | hidden | fraction | g | r | s
      s2_rnd   <= s1_rnd;
    end
  end

endmodule

/* verilog/fp_align.sv */
`timescale 1ns/1ns
module fp_align (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 in_valid,
  input  logic [fp_format_pkg::WORD_W-1:0]     a,
  input  logic [fp_format_pkg::WORD_W-1:0]     b,
  input  fp_ctrl_pkg::fp_op_e                  op,
  input  fp_ctrl_pkg::fp_rnd_e                 rnd_mode,
  output logic                                 s1_valid,
  output logic                                 s1_sign,
  output logic                                 s1_eff_sub,
  output logic [fp_format_pkg::EXP_W-1:0]      s1_exp,
  output logic [fp_format_pkg::ALIGN_W-1:0]    s1_sig_big,
  output logic [fp_format_pkg::ALIGN_W-1:0]    s1_sig_small,
  output logic [1:0]                           s1_rnd
);
  logic                                 sign_a, sign_b;
  logic [fp_format_pkg::EXP_W-1:0]      exp_a, exp_b, exp_big, exp_small, diff;
  logic [fp_format_pkg::SIG_W-1:0]      sig_a, sig_b, sig_big, sig_small;
  logic                                 a_big;
  logic [2*fp_format_pkg::ALIGN_W-1:0]  shift_full; // upper half kept, lower half to sticky
  logic [fp_format_pkg::ALIGN_W-1:0]    small_al;

  // unpack
  assign sign_a = a[fp_format_pkg::WORD_W-1];
  assign sign_b = b[fp_format_pkg::WORD_W-1] ^ (op == fp_ctrl_pkg::OP_SUB); // b negated on sub
  assign exp_a  = a[fp_format_pkg::WORD_W-2 -: fp_format_pkg::EXP_W];
  assign exp_b  = b[fp_format_pkg::WORD_W-2 -: fp_format_pkg::EXP_W];
  // zero exponent flushes the whole significand
  assign sig_a = (exp_a == '0) ? '0 : {1'b1, a[fp_format_pkg::MANT_W-1:0]};
  assign sig_b = (exp_b == '0) ? '0 : {1'b1, b[fp_format_pkg::MANT_W-1:0]};

  // exp|frac compares as an unsigned magnitude
  assign a_big = a[fp_format_pkg::WORD_W-2:0] >= b[fp_format_pkg::WORD_W-2:0];

  assign exp_big   = a_big ? exp_a : exp_b;
  assign exp_small = a_big ? exp_b : exp_a;
  assign sig_big   = a_big ? sig_a : sig_b;
  assign sig_small = a_big ? sig_b : sig_a;
  assign diff      = exp_big - exp_small; // never negative

  always_comb begin
    shift_full = {sig_small, 3'b000, {fp_format_pkg::ALIGN_W{1'b0}}} >> diff;
    if (diff > fp_format_pkg::ALIGN_W - 1) begin
      small_al = {{(fp_format_pkg::ALIGN_W-1){1'b0}}, |sig_small}; // only sticky survives
    end else begin
      small_al = {shift_full[2*fp_format_pkg::ALIGN_W-1:fp_format_pkg::ALIGN_W+1],
                  shift_full[fp_format_pkg::ALIGN_W] |
                  (|shift_full[fp_format_pkg::ALIGN_W-1:0])}; // fold lost bits into s
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid     <= 1'b0;
      s1_sign      <= 1'b0;
      s1_eff_sub   <= 1'b0;
      s1_exp       <= '0;
      s1_sig_big   <= '0;
      s1_sig_small <= '0;
      s1_rnd       <= '0;
    end else begin
      s1_valid     <= in_valid;
      s1_sign      <= a_big ? sign_a : sign_b; // larger magnitude decides the sign
      s1_eff_sub   <= sign_a ^ sign_b;
      s1_exp       <= exp_big;
      s1_sig_big   <= {sig_big, 3'b000}; // grs start empty
      s1_sig_small <= small_al;
      s1_rnd       <= rnd_mode;
    end
  end

endmodule

/* verilog/fp_ctrl_pkg.sv */
package fp_ctrl_pkg;

  // operation request from the user side
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } fp_op_e;

  // two-bit rounding mode
  typedef enum logic [1:0] {
    RND_NE = 2'b00, // nearest, ties to even
    RND_RZ = 2'b01, // toward zero
    RND_RP = 2'b10, // toward +inf
    RND_RM = 2'b11  // toward -inf
  } fp_rnd_e;

endpackage

/* verilog/fp_format_pkg.sv */
package fp_format_pkg;

  // single precision field widths
  localparam int EXP_W  = 8;
  localparam int MANT_W = 23;
  localparam int WORD_W = 32;

  // significand with hidden one
  localparam int SIG_W = MANT_W + 1;

  // aligned operand is hidden + fraction + g + r + s
  localparam int ALIGN_W = SIG_W + 3;

  // adder output adds a carry bit on top
  localparam int WORK_W = MANT_W + 5;

  // special exponent codes
  localparam logic [EXP_W-1:0] EXP_MAX        = '1;
  localparam logic [EXP_W-1:0] MAX_FINITE_EXP = EXP_MAX - 1'b1;

endpackage
